// File: include/dcache_config.svh
// data cache geometry, word width and poison value macros
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// datapath word and address width
`define DCACHE_WORD_W 32

// eight sets, so three index bits
`define DCACHE_IDX_W 3

// tag is what remains above index, block offset and byte offset
`define DCACHE_TAG_W 26

// two-way set associative
`define DCACHE_WAYS 2

// driven on data and address outputs that carry nothing
`define DCACHE_POISON 32'hBAD1BAD1

`endif

// File: design/dcache_pkg.sv
// word, address split, cache line and controller state types
`include "dcache_config.svh"

package dcache_pkg;

  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // split of a datapath address, byte offset is ignored
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0] tag;
    logic [`DCACHE_IDX_W-1:0] idx;
    logic                     blkoff;
    logic [1:0]               bytoff;
  } dcache_addr_t;

  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0] tag;
    word_t [1:0]              data;
    logic                     valid;
    logic                     dirty;
  } dcache_line_t;

  typedef enum logic [3:0] {
    IDLE, WB_WORD0, WB_WORD1,
    FILL_WORD0, FILL_WORD1,
    FLUSH_SCAN, FLUSH_WORD0, FLUSH_WORD1,
    FLUSHED
  } dcache_state_e;

endpackage

// File: design/dcache_array_if.sv
// lookup, victim and update signals between cache controller and line storage
`timescale 1ns/1ps
`include "dcache_config.svh"

interface dcache_array_if
  import dcache_pkg::*;
();
  // lookup, driven by the controller
  logic [`DCACHE_IDX_W-1:0] idx;
  logic [`DCACHE_TAG_W-1:0] tag;
  logic                     sel_way;      // way for line_data and all updates

  // lookup results
  logic                     hit;
  logic                     hit_way;
  word_t [1:0]              hit_data;
  logic                     victim_way;   // lru way of the set
  logic [`DCACHE_TAG_W-1:0] victim_tag;
  logic                     victim_valid;
  logic                     victim_dirty;
  dcache_line_t             line_data;    // whole line at idx and sel_way

  // updates, applied at the clock edge
  logic                     wr_word;      // store hit, sets dirty
  logic                     wr_word_sel;  // word offset for store and fill
  logic                     fill_word;
  word_t                    fill_data;    // store data or fill word
  logic                     fill_done;
  logic                     mark_clean;
  logic                     touch;

  modport ctrl (
    output idx, tag, sel_way, wr_word, wr_word_sel, fill_word, fill_data,
    output fill_done, mark_clean, touch,
    input  hit, hit_way, hit_data, victim_way, victim_tag, victim_valid,
    input  victim_dirty, line_data
  );

  modport array (
    input  idx, tag, sel_way, wr_word, wr_word_sel, fill_word, fill_data,
    input  fill_done, mark_clean, touch,
    output hit, hit_way, hit_data, victim_way, victim_tag, victim_valid,
    output victim_dirty, line_data
  );

endinterface

// File: design/dcache_array.sv
// tag, data, valid, dirty and lru storage with hit compare and update port
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_array
  import dcache_pkg::*;
(
  input  logic          CLK,
  input  logic          nRST,
  dcache_array_if.array arr
);

  localparam int SETS = 1 << `DCACHE_IDX_W;

  logic [`DCACHE_TAG_W-1:0] tag_mem  [`DCACHE_WAYS][SETS];
  word_t [1:0]              data_mem [`DCACHE_WAYS][SETS];

  logic [`DCACHE_WAYS-1:0][SETS-1:0] valid;
  logic [`DCACHE_WAYS-1:0][SETS-1:0] dirty;
  logic [SETS-1:0]                   lru;      // way to replace next in each set
  logic [`DCACHE_WAYS-1:0]           way_hit;

  always_comb begin
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      way_hit[w] = valid[w][arr.idx] && (tag_mem[w][arr.idx] == arr.tag);
    end
  end

  assign arr.hit      = |way_hit;
  assign arr.hit_way  = way_hit[1];          // way 0 when neither matches
  assign arr.hit_data = data_mem[arr.hit_way][arr.idx];

  // victim view follows the lru bit of the set
  assign arr.victim_way   = lru[arr.idx];
  assign arr.victim_tag   = tag_mem[arr.victim_way][arr.idx];
  assign arr.victim_valid = valid[arr.victim_way][arr.idx];
  assign arr.victim_dirty = dirty[arr.victim_way][arr.idx];

  assign arr.line_data = '{
    tag:   tag_mem[arr.sel_way][arr.idx],
    data:  data_mem[arr.sel_way][arr.idx],
    valid: valid[arr.sel_way][arr.idx],
    dirty: dirty[arr.sel_way][arr.idx]
  };

  // line status and replacement state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (arr.wr_word) begin
        dirty[arr.sel_way][arr.idx] <= 1'b1;
      end
      if (arr.fill_done) begin
        valid[arr.sel_way][arr.idx] <= 1'b1;
        dirty[arr.sel_way][arr.idx] <= 1'b0;
      end
      if (arr.mark_clean) begin
        dirty[arr.sel_way][arr.idx] <= 1'b0;
      end
      if (arr.touch) begin
        lru[arr.idx] <= ~arr.sel_way;  // other way becomes lru
      end
    end
  end

  // payload storage
  always_ff @(posedge CLK) begin
    if (arr.wr_word || arr.fill_word) begin
      data_mem[arr.sel_way][arr.idx][arr.wr_word_sel] <= arr.fill_data;
    end
    if (arr.fill_done) begin
      tag_mem[arr.sel_way][arr.idx] <= arr.tag;
    end
  end

endmodule

// File: design/flush_walker.sv
// slot counter stepping over every way and set during a flush
`timescale 1ns/1ps
`include "dcache_config.svh"

module flush_walker (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   step,
  output logic [`DCACHE_IDX_W:0] slot,
  output logic                   last
);

  // upper bit is the way, lower bits the set, so way 0 is walked first
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      slot <= '0;
    end else if (step) begin
      slot <= slot + 1'b1;   // wraps to zero after the last slot
    end
  end

  assign last = &slot;

endmodule

// File: design/dcache_ctrl.sv
// cache controller FSM for hits, write-back, fill, flush and memory bus outputs
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   dmem_ren,
  input  logic                   dmem_wen,
  input  word_t                  dmem_addr,
  input  word_t                  dmem_store,
  input  logic                   halt,
  input  logic                   mem_wait,
  input  word_t                  mem_load,
  output logic                   dhit,
  output word_t                  dmem_load,
  output logic                   flushed,
  output logic                   mem_ren,
  output logic                   mem_wen,
  output word_t                  mem_addr,
  output word_t                  mem_store,
  dcache_array_if.ctrl           arr,
  output logic                   walk_step,
  input  logic [`DCACHE_IDX_W:0] walk_slot,
  input  logic                   walk_last
);

  dcache_state_e            state, state_nxt;
  dcache_addr_t             req;
  logic                     flush_mode;  // walker owns the array index
  logic                     word_sel;    // second word of the block
  logic [`DCACHE_TAG_W-1:0] wb_tag;

  assign req        = dmem_addr;
  assign flush_mode = (state == FLUSH_SCAN) || (state == FLUSH_WORD0) ||
                      (state == FLUSH_WORD1);
  assign word_sel   = (state == WB_WORD1) || (state == FILL_WORD1) ||
                      (state == FLUSH_WORD1);
  assign wb_tag     = flush_mode ? arr.line_data.tag : arr.victim_tag;
  assign flushed    = (state == FLUSHED);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // array addressing
  always_comb begin
    arr.tag = req.tag;
    if (flush_mode) begin
      arr.idx     = walk_slot[`DCACHE_IDX_W-1:0];
      arr.sel_way = walk_slot[`DCACHE_IDX_W];
    end else begin
      arr.idx     = req.idx;
      arr.sel_way = (state == IDLE) ? arr.hit_way : arr.victim_way;
    end
  end

  always_comb begin
    state_nxt       = state;
    dhit            = 1'b0;
    dmem_load       = `DCACHE_POISON;
    mem_ren         = 1'b0;
    mem_wen         = 1'b0;
    mem_addr        = `DCACHE_POISON;
    mem_store       = `DCACHE_POISON;
    walk_step       = 1'b0;
    arr.wr_word     = 1'b0;
    arr.wr_word_sel = req.blkoff;
    arr.fill_word   = 1'b0;
    arr.fill_data   = dmem_store;
    arr.fill_done   = 1'b0;
    arr.mark_clean  = 1'b0;
    arr.touch       = 1'b0;

    case (state)
      IDLE: begin
        if (dmem_ren || dmem_wen) begin
          if (arr.hit) begin
            dhit      = 1'b1;
            arr.touch = 1'b1;
            if (dmem_ren) begin
              dmem_load = arr.hit_data[req.blkoff];
            end else begin
              arr.wr_word = 1'b1;
            end
          end else if (arr.victim_valid && arr.victim_dirty) begin
            state_nxt = WB_WORD0;   // victim must go out first
          end else begin
            state_nxt = FILL_WORD0;
          end
        end else if (halt) begin
          state_nxt = FLUSH_SCAN;
        end
      end

      // miss victim and flushed line share the write path
      WB_WORD0, WB_WORD1, FLUSH_WORD0, FLUSH_WORD1: begin
        mem_wen   = 1'b1;
        mem_addr  = {wb_tag, arr.idx, word_sel, 2'b00};
        mem_store = arr.line_data.data[word_sel];
        if (!mem_wait) begin
          case (state)
            WB_WORD0:    state_nxt = WB_WORD1;
            WB_WORD1:    state_nxt = FILL_WORD0;
            FLUSH_WORD0: state_nxt = FLUSH_WORD1;
            default: begin
              arr.mark_clean = 1'b1;
              walk_step      = 1'b1;
              state_nxt      = walk_last ? FLUSHED : FLUSH_SCAN;
            end
          endcase
        end
      end

      FILL_WORD0, FILL_WORD1: begin
        mem_ren         = 1'b1;
        mem_addr        = {req.tag, req.idx, word_sel, 2'b00};
        arr.wr_word_sel = word_sel;
        arr.fill_data   = mem_load;
        if (!mem_wait) begin
          arr.fill_word = 1'b1;
          arr.fill_done = word_sel;   // tag and valid land with the last word
          state_nxt     = word_sel ? IDLE : FILL_WORD1;
        end
      end

      FLUSH_SCAN: begin
        if (arr.line_data.valid && arr.line_data.dirty) begin
          state_nxt = FLUSH_WORD0;
        end else begin
          walk_step = 1'b1;   // clean or empty slot, skip it
          if (walk_last) begin
            state_nxt = FLUSHED;
          end
        end
      end

      default: ;  // FLUSHED holds and ignores requests
    endcase
  end

endmodule

// File: design/dcache_top.sv
// cache top level joining controller, line storage and flush walker
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  output logic  dhit,
  output word_t dmem_load,
  output logic  flushed,
  output logic  mem_ren,
  output logic  mem_wen,
  output word_t mem_addr,
  output word_t mem_store,
  input  word_t mem_load,
  input  logic  mem_wait
);

  dcache_array_if arr_if ();

  logic                   walk_step;
  logic [`DCACHE_IDX_W:0] walk_slot;
  logic                   walk_last;

  dcache_ctrl u_ctrl (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .halt       (halt),
    .mem_wait   (mem_wait),
    .mem_load   (mem_load),
    .dhit       (dhit),
    .dmem_load  (dmem_load),
    .flushed    (flushed),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_addr   (mem_addr),
    .mem_store  (mem_store),
    .arr        (arr_if.ctrl),
    .walk_step  (walk_step),
    .walk_slot  (walk_slot),
    .walk_last  (walk_last)
  );

  dcache_array u_array (
    .CLK  (CLK),
    .nRST (nRST),
    .arr  (arr_if.array)
  );

  flush_walker u_walker (
    .CLK  (CLK),
    .nRST (nRST),
    .step (walk_step),
    .slot (walk_slot),
    .last (walk_last)
  );

endmodule

// File: tests/tb_clock.sv
// free-running testbench clock with a 40 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;   // half period
  end

endmodule

// File: tests/dcache_sva.sv
// bound checks for memory bus direction, address hold, reset state and flush status
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_sva (
  input logic                      CLK,
  input logic                      nRST,
  input logic                      dhit,
  input logic                      flushed,
  input logic                      mem_ren,
  input logic                      mem_wen,
  input logic                      mem_wait,
  input logic [`DCACHE_WORD_W-1:0] mem_addr
);

  a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
    else $error("mem_ren and mem_wen high in the same cycle");

  // a stalled word keeps its address and direction
  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr) && $stable(mem_ren) && $stable(mem_wen))
    else $error("memory request changed while mem_wait was high");

  a_reset: assert property (@(posedge CLK) !nRST |-> !(dhit || flushed || mem_ren || mem_wen))
    else $error("control outputs not low during reset");

  a_flushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else $error("flushed fell after the flush");

endmodule

// File: tests/dcache_tb.sv
// data cache testbench with memory model, case player, shadow memory and watchdog
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb
  import dcache_pkg::*;
();

  localparam int SETS = 1 << `DCACHE_IDX_W;

  logic  CLK, nRST, dmem_ren, dmem_wen, halt, dhit, flushed;
  logic  mem_ren, mem_wen, mem_wait;
  word_t dmem_addr, dmem_store, dmem_load, mem_addr, mem_store, mem_load;

  logic [99:0] cases [32];       // op, address, store data, expected
  word_t       mem    [word_t];  // sparse memory model, keyed by byte address
  word_t       shadow [word_t];  // every datapath store
  int          n_cases = 0;
  int          flush_writes;

  // tags and lru bits of a reference cache, to tell which accesses must hit
  logic [`DCACHE_TAG_W-1:0]          ref_tag [SETS][`DCACHE_WAYS];
  logic [SETS-1:0][`DCACHE_WAYS-1:0] ref_valid;
  logic [SETS-1:0]                   ref_lru;    // way filled on the next miss

  tb_clock u_clock (.CLK(CLK));

  dcache_top u_dcache_top (.*);

  bind dcache_top dcache_sva u_sva (
    .CLK(CLK), .nRST(nRST), .dhit(dhit), .flushed(flushed),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wait(mem_wait), .mem_addr(mem_addr)
  );

  // untouched words hold their own address inverted
  function automatic word_t mem_rd(word_t a);
    return mem.exists(a) ? mem[a] : ~a;
  endfunction

  function automatic word_t shadow_rd(word_t a);
    return shadow.exists(a) ? shadow[a] : ~a;
  endfunction

  // a miss fills the lru way and every access makes the other way lru
  function automatic logic lookup_ref(word_t a);
    dcache_addr_t f;
    logic         is_hit;
    logic         way;
    f      = a;
    is_hit = 1'b0;
    way    = ref_lru[f.idx];
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (ref_valid[f.idx][w] && (ref_tag[f.idx][w] == f.tag)) begin
        is_hit = 1'b1;
        way    = w[0];
      end
    end
    ref_tag[f.idx][way]   = f.tag;
    ref_valid[f.idx][way] = 1'b1;
    ref_lru[f.idx]        = ~way;
    return is_hit;
  endfunction

  task automatic report_mismatch(string sig, word_t exp_v, word_t act_v);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_error(string what);
    $display("%0t ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  always_comb mem_load = mem_rd(mem_addr);

  // memory model, the wait count for the next word is drawn when a word transfers
  initial begin
    int wait_left;
    mem_wait     = 1'b0;
    flush_writes = 0;
    wait_left    = 0;
    wait (nRST);
    void'($urandom(32'h40a6cd3e));
    forever begin
      @(posedge CLK);
      if (mem_ren || mem_wen) begin
        if (!mem_wait) begin
          if (mem_wen) begin
            assert (mem_store == shadow_rd(mem_addr))
              else report_mismatch("mem_store", shadow_rd(mem_addr), mem_store);
            mem[mem_addr] = mem_store;
            if (halt) begin
              flush_writes++;
            end
          end
          wait_left = $urandom_range(3, 0);
        end else begin
          wait_left--;
        end
        mem_wait <= (wait_left != 0);
      end
    end
  end

  task automatic play_case(logic [99:0] c);
    logic [3:0] op;
    word_t      addr;
    word_t      expect_v;
    logic       hit_exp;
    op       = c[99:96];
    addr     = c[95:64];
    expect_v = c[31:0];
    @(posedge CLK);
    if (op == 4'h2) begin
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
      halt     <= 1'b1;
      do @(negedge CLK); while (!flushed);
      assert (flush_writes == expect_v)  // clean lines must not be written
        else report_mismatch("flush write count", expect_v, word_t'(flush_writes));
      foreach (shadow[a]) begin
        assert (mem_rd(a) == shadow[a])
          else report_mismatch($sformatf("mem[%h]", a), shadow[a], mem_rd(a));
      end
      // requests after the flush get no answer and no bus traffic
      @(posedge CLK);
      dmem_ren  <= 1'b1;
      dmem_addr <= addr;
      repeat (4) begin
        @(negedge CLK);
        assert (flushed && !dhit && !mem_ren && !mem_wen)
          else report_error("cache reacted to a request after the flush");
      end
    end else begin
      hit_exp     = lookup_ref(addr);
      dmem_ren   <= (op == 4'h0);
      dmem_wen   <= (op == 4'h1);
      dmem_addr  <= addr;
      dmem_store <= c[63:32];
      @(negedge CLK);
      assert (dhit == hit_exp)   // a hit answers in the cycle of the request
        else report_mismatch("dhit", word_t'(hit_exp), word_t'(dhit));
      while (!dhit) begin
        @(negedge CLK);
      end
      if (op == 4'h0) begin
        assert (dmem_load == expect_v) else report_mismatch("dmem_load", expect_v, dmem_load);
        assert (dmem_load == shadow_rd(addr))
          else report_mismatch("dmem_load vs shadow", shadow_rd(addr), dmem_load);
      end else begin
        shadow[addr] = c[63:32];   // the cache takes it at the next edge
      end
    end
  endtask

  initial begin
    wait (n_cases > 0);
    repeat (200 * n_cases + 8) @(posedge CLK);
    report_error($sformatf("watchdog expired after %0d cycles", 200 * n_cases + 8));
  end

  initial begin
    nRST       = 1'b0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    dmem_addr  = '0;
    dmem_store = '0;
    halt       = 1'b0;
    ref_valid  = '0;
    ref_lru    = '0;   // way 0 is filled first after reset
    foreach (cases[i]) begin
      cases[i] = '1;   // op F marks an unused entry
    end
    $readmemh("tests/dcache_cases.txt", cases);
    foreach (cases[i]) begin
      if (cases[i][99:96] != 4'hF) begin
        n_cases++;
      end
    end
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    foreach (cases[i]) begin
      if (cases[i][99:96] != 4'hF) begin
        play_case(cases[i]);
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: tests/dcache_cases.txt
// op (0 read, 1 write, 2 halt) _ byte address _ store data _ expected
// expected is the load for a read and the number of flush writes for halt
0_00000010_00000000_FFFFFFEF
0_00000014_00000000_FFFFFFEB
0_00000010_00000000_FFFFFFEF
1_00000020_A5A50001_00000000
0_00000020_00000000_A5A50001
1_00000024_5A5A0002_00000000
0_00000024_00000000_5A5A0002
1_00000000_11110000_00000000
0_00000044_00000000_FFFFFFBB
0_00000080_00000000_FFFFFF7F
0_00000000_00000000_11110000
1_00000084_22220084_00000000
1_00000108_33330108_00000000
0_00000040_00000000_FFFFFFBF
0_00000084_00000000_22220084
1_0000003C_4444003C_00000000
0_00000038_00000000_FFFFFFC7
2_00000000_00000000_00000008

// File: dcache_top.f
+incdir+include
design/dcache_pkg.sv
design/dcache_array_if.sv
design/dcache_array.sv
design/flush_walker.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tests/tb_clock.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

// File: Makefile
obj_dir/Vdcache_tb: dcache_top.f $(wildcard include/*.svh design/*.sv tests/*.sv)
	verilator --binary --timing --assert -f dcache_top.f --top-module dcache_tb -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
